// File: cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address and data widths
`define CACHE_ADDR_W    32
`define CACHE_WORD_W    64

// geometry, 2-way x 128 sets x 16-byte lines
`define CACHE_SETS      128
`define CACHE_WAYS      2
`define CACHE_TAG_W     21   // addr[31:11]
`define CACHE_INDEX_W   7    // addr[10:4]
`define CACHE_OFFSET_W  4    // addr[3:0], bit 3 picks the word

// request queue in front of the controller
`define CACHE_QUEUE_DEPTH 2

`endif

// File: cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`CACHE_WORD_W-1:0]   word_t;
    typedef logic [`CACHE_WORD_W/8-1:0] strb_t;
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
        strb_t strb;   // one bit per byte lane
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_resp_t;

    // address field extraction
    function automatic tag_t addr_tag(addr_t a);
        return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    endfunction

    function automatic logic addr_word(addr_t a);
        return a[`CACHE_OFFSET_W-1];   // word within the line
    endfunction

    // old bytes where strobe is low, new bytes where high
    function automatic word_t merge_strb(word_t old_word, word_t new_word, strb_t strb);
        word_t res;
        res = old_word;
        for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package mem_pkg;

    // beats per line on the memory side
    localparam int LINE_BEATS = 2;

    typedef logic [`CACHE_WORD_W-1:0] beat_t;

    // beat 0 sits at the line base, beat 1 at base + 8
    typedef beat_t [LINE_BEATS-1:0] line_t;

endpackage

`default_nettype wire

// File: line_xfer_if.sv
`timescale 1ns/1ns
`default_nettype none

interface line_xfer_if;
    import cache_pkg::*;
    import mem_pkg::*;

    logic  start;       // held until done
    logic  write;       // 1 = write-back, 0 = refill
    addr_t line_addr;   // line base address
    line_t wline;       // victim data for write-back
    logic  done;        // one-cycle pulse
    line_t rline;       // refill data, valid with done

    modport controller (
        output start,
        output write,
        output line_addr,
        output wline,
        input  done,
        input  rline
    );

    modport mover (
        input  start,
        input  write,
        input  line_addr,
        input  wline,
        output done,
        output rline
    );

endinterface

`default_nettype wire

// File: req_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module req_queue #(
    parameter type payload_t = cache_pkg::cpu_req_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int DEPTH = `CACHE_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));  // low only when all slots full
    assign out_valid = (count != '0);
    assign out_data  = slots[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  cache_pkg::cpu_req_t  req,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output cache_pkg::cpu_resp_t resp,
    line_xfer_if.controller      xfer
);
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int WAY_W = (`CACHE_WAYS > 1) ? $clog2(`CACHE_WAYS) : 1;
    localparam int OFF_W = `CACHE_OFFSET_W;

    typedef logic [WAY_W-1:0] way_t;
    typedef enum logic [1:0] {S_IDLE, S_WB, S_REFILL, S_RESP} state_t;

    // tag, state and data stores
    tag_t  tag_mem   [`CACHE_WAYS][`CACHE_SETS];
    logic  valid_mem [`CACHE_WAYS][`CACHE_SETS];
    logic  dirty_mem [`CACHE_WAYS][`CACHE_SETS];
    line_t data_mem  [`CACHE_WAYS][`CACHE_SETS];

    state_t   state;
    way_t     victim_q;   // round-robin pointer
    way_t     way_q;      // way being replaced
    cpu_req_t req_q;
    word_t    resp_q;

    index_t idx;
    tag_t   tag;
    logic   wsel;
    index_t idx_q;
    logic   wsel_q;
    logic   hit;
    way_t   hit_way;
    way_t   fill_way;
    logic   all_valid;
    logic   wb_needed;
    word_t  old_word;
    word_t  hit_word;
    word_t  refill_word;
    line_t  refill_line;

    assign idx    = addr_index(req.addr);
    assign tag    = addr_tag(req.addr);
    assign wsel   = addr_word(req.addr);
    assign idx_q  = addr_index(req_q.addr);
    assign wsel_q = addr_word(req_q.addr);

    // lookup on the request at the queue head
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        fill_way  = victim_q;
        all_valid = 1'b1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (valid_mem[w][idx] && tag_mem[w][idx] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
        // lowest invalid way wins over the round-robin choice
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_mem[w][idx]) begin
                fill_way  = way_t'(w);
                all_valid = 1'b0;
            end
        end
    end

    assign wb_needed = all_valid && dirty_mem[fill_way][idx];
    assign old_word  = data_mem[hit_way][idx][wsel];
    assign hit_word  = req.write ? merge_strb(old_word, req.wdata, req.strb) : old_word;

    // store merged into the refilled line
    always_comb begin
        refill_line = xfer.rline;
        refill_word = xfer.rline[wsel_q];
        if (req_q.write) begin
            refill_word = merge_strb(xfer.rline[wsel_q], req_q.wdata, req_q.strb);
        end
        refill_line[wsel_q] = refill_word;
    end

    assign req_ready  = (state == S_IDLE);
    assign resp_valid = (state == S_RESP);
    assign resp.rdata = resp_q;

    assign xfer.start     = (state == S_WB) || (state == S_REFILL);
    assign xfer.write     = (state == S_WB);
    assign xfer.wline     = data_mem[way_q][idx_q];
    assign xfer.line_addr = {(state == S_WB) ? tag_mem[way_q][idx_q] : addr_tag(req_q.addr),
                             idx_q, OFF_W'(0)};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            victim_q <= '0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    valid_mem[w][s] <= 1'b0;
                    dirty_mem[w][s] <= 1'b0;
                end
            end
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        if (hit) begin
                            if (req.write) begin
                                dirty_mem[hit_way][idx] <= 1'b1;
                            end
                            state <= S_RESP;
                        end else begin
                            if (all_valid) begin
                                victim_q <= victim_q + 1'b1;   // evicting a valid line
                            end
                            state <= wb_needed ? S_WB : S_REFILL;
                        end
                    end
                end
                S_WB: begin
                    if (xfer.done) begin
                        state <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (xfer.done) begin
                        valid_mem[way_q][idx_q] <= 1'b1;
                        dirty_mem[way_q][idx_q] <= req_q.write;
                        state                   <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (resp_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            req_q  <= req;
            way_q  <= fill_way;
            resp_q <= hit_word;   // only meaningful on a hit
            if (hit && req.write) begin
                data_mem[hit_way][idx][wsel] <= hit_word;
            end
        end
        if (state == S_REFILL && xfer.done) begin
            tag_mem[way_q][idx_q]  <= addr_tag(req_q.addr);
            data_mem[way_q][idx_q] <= refill_line;
            resp_q                 <= refill_word;
        end
    end

endmodule

`default_nettype wire

// File: line_mover.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module line_mover (
    input  logic             clk,
    input  logic             rst,
    line_xfer_if.mover       xfer,
    output logic             mem_valid,
    input  logic             mem_ready,
    output logic             mem_write,
    output cache_pkg::addr_t mem_addr,
    output mem_pkg::beat_t   mem_wdata,
    input  logic             mem_rvalid,
    input  mem_pkg::beat_t   mem_rdata
);
    import mem_pkg::*;

    localparam int BEAT_W = $clog2(LINE_BEATS);
    localparam int BYTE_W = `CACHE_OFFSET_W - BEAT_W;

    typedef enum logic [1:0] {M_IDLE, M_SEND, M_WAIT, M_DONE} state_t;

    state_t            state;
    logic [BEAT_W-1:0] beat_cnt;      // next beat to issue
    logic [BEAT_W-1:0] rd_idx;        // slot for next read response
    logic [1:0]        outstanding;   // reads issued, not yet answered
    logic              rd_issue;
    line_t             rline_q;

    assign mem_valid = (state == M_SEND);
    assign mem_write = xfer.write;
    assign mem_wdata = xfer.wline[beat_cnt];
    assign mem_addr  = {xfer.line_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], beat_cnt, BYTE_W'(0)};
    assign rd_issue  = mem_valid && mem_ready && !xfer.write;

    assign xfer.done  = (state == M_DONE);
    assign xfer.rline = rline_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= M_IDLE;
            beat_cnt    <= '0;
            rd_idx      <= '0;
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 2'(rd_issue) - 2'(mem_rvalid);
            if (mem_rvalid) begin
                rd_idx <= rd_idx + 1'b1;   // wraps after the last beat
            end
            case (state)
                M_IDLE: begin
                    if (xfer.start) begin
                        state <= M_SEND;
                    end
                end
                M_SEND: begin
                    if (mem_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == BEAT_W'(LINE_BEATS - 1)) begin
                            state <= M_WAIT;
                        end
                    end
                end
                M_WAIT: begin
                    if (outstanding == '0) begin   // writes pass straight through
                        state <= M_DONE;
                    end
                end
                default: state <= M_IDLE;   // M_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rvalid) begin
            rline_q[rd_idx] <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      rst,
    // cpu request
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [`CACHE_ADDR_W-1:0]  req_addr,
    input  logic                      req_write,
    input  logic [`CACHE_WORD_W-1:0]  req_wdata,
    input  logic [`CACHE_WORD_W/8-1:0] req_strb,
    // cpu response
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output logic [`CACHE_WORD_W-1:0]  resp_rdata,
    // memory side
    output logic                      mem_valid,
    input  logic                      mem_ready,
    output logic                      mem_write,
    output logic [`CACHE_ADDR_W-1:0]  mem_addr,
    output logic [`CACHE_WORD_W-1:0]  mem_wdata,
    input  logic                      mem_rvalid,
    input  logic [`CACHE_WORD_W-1:0]  mem_rdata
);
    import cache_pkg::*;

    cpu_req_t  q_in;
    cpu_req_t  q_out;
    logic      q_valid;
    logic      q_ready;
    cpu_resp_t resp;

    assign q_in.addr  = req_addr;
    assign q_in.write = req_write;
    assign q_in.wdata = req_wdata;
    assign q_in.strb  = req_strb;
    assign resp_rdata = resp.rdata;

    line_xfer_if xfer ();

    req_queue #(
        .payload_t (cpu_req_t)
    ) i_req_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (q_in),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_data  (q_out)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (q_valid),
        .req_ready  (q_ready),
        .req        (q_out),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .xfer       (xfer)
    );

    line_mover i_line_mover (
        .clk        (clk),
        .rst        (rst),
        .xfer       (xfer),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module tb_dcache;
    import cache_pkg::*;

    // the five tests together need a few hundred cycles
    localparam int TIMEOUT_CYCLES = 4000;

    typedef logic [`CACHE_ADDR_W-4:0] waddr_t;   // word address, addr[31:3]

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;
    logic  req_write;
    word_t req_wdata;
    strb_t req_strb;
    logic  resp_valid;
    logic  resp_ready;
    word_t resp_rdata;
    logic  mem_valid;
    logic  mem_ready;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_rvalid = 1'b0;
    word_t mem_rdata = '0;

    integer seed;
    int     cyc = 0;
    word_t  mem_words [waddr_t];   // backing memory
    word_t  shadow [waddr_t];      // what the CPU should see
    addr_t  cmd_addr_q [$];
    logic   cmd_write_q [$];
    word_t  cmd_data_q [$];
    word_t  rsp_data_q [$];
    int     rsp_due_q [$];

    dcache_top i_dcache_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .req_strb   (req_strb),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            report_fail($sformatf("run timed out after %0d cycles", cyc));
        end
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            report_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    // words get their random content on first touch
    function automatic void ensure_word(input addr_t a);
        word_t v;
        if (!mem_words.exists(a[`CACHE_ADDR_W-1:3])) begin
            v[63:32] = $random(seed);
            v[31:0]  = $random(seed);
            mem_words[a[`CACHE_ADDR_W-1:3]] = v;
            shadow[a[`CACHE_ADDR_W-1:3]]    = v;
        end
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        ensure_word(a);
        return shadow[a[`CACHE_ADDR_W-1:3]];
    endfunction

    function automatic word_t apply_strobe(input word_t old_w, input word_t new_w,
                                           input strb_t st);
        word_t mask;
        for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
            mask[8*b +: 8] = {8{st[b]}};
        end
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic void update_shadow(input addr_t a, input word_t wd, input strb_t st);
        shadow[a[`CACHE_ADDR_W-1:3]] = apply_strobe(shadow_word(a), wd, st);
    endfunction

    // memory commands, sampled at negedge where DUT outputs have settled
    always @(negedge clk) begin
        if (!rst && mem_valid && mem_ready) begin
            cmd_addr_q.push_back(mem_addr);
            cmd_write_q.push_back(mem_write);
            cmd_data_q.push_back(mem_wdata);
            if (mem_write) begin
                mem_words[mem_addr[`CACHE_ADDR_W-1:3]] = mem_wdata;
            end else begin
                ensure_word(mem_addr);
                rsp_data_q.push_back(mem_words[mem_addr[`CACHE_ADDR_W-1:3]]);
                rsp_due_q.push_back(cyc + 2);   // two edges after acceptance
            end
        end
    end

    always @(posedge clk) begin
        #10;
        if (rsp_due_q.size() > 0 && rsp_due_q[0] == cyc) begin
            mem_rvalid = 1'b1;
            mem_rdata  = rsp_data_q.pop_front();
            void'(rsp_due_q.pop_front());
        end else begin
            mem_rvalid = 1'b0;
        end
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic send_req(input addr_t a, input logic wr, input word_t wd, input strb_t st);
        req_valid = 1'b1;
        req_addr  = a;
        req_write = wr;
        req_wdata = wd;
        req_strb  = st;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        step();   // taken on this edge
        req_valid = 1'b0;
    endtask

    task automatic take_resp(output word_t rd);
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
        end
        rd = resp_rdata;
        step();
    endtask

    task automatic access(input addr_t a, input logic wr, input word_t wd, input strb_t st,
                          output word_t rd);
        send_req(a, wr, wd, st);
        take_resp(rd);
    endtask

    task automatic clear_log();
        cmd_addr_q.delete();
        cmd_write_q.delete();
        cmd_data_q.delete();
    endtask

    task automatic expect_cmd(input int i, input logic wr, input addr_t a);
        check_flag("mem_write", cmd_write_q[i], wr);
        check_addr("mem_addr", cmd_addr_q[i], a);
    endtask

    task automatic reset_state();
        addr_t a;
        word_t exp;
        word_t got;
        a = 32'h0000_1238;
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("mem_valid", mem_valid, 1'b0);
        clear_log();
        exp = shadow_word(a);
        access(a, 1'b0, '0, '0, got);
        check_word("resp_rdata", got, exp);
        check_count("mem commands", cmd_addr_q.size(), 2);
        expect_cmd(0, 1'b0, 32'h0000_1230);   // refill starts at line base
        expect_cmd(1, 1'b0, 32'h0000_1238);
    endtask

    task automatic miss_then_hit();
        addr_t a;
        word_t got;
        a = 32'h0000_2340;
        access(a, 1'b0, '0, '0, got);
        check_word("resp_rdata", got, shadow_word(a));
        clear_log();
        access(a + 32'd8, 1'b0, '0, '0, got);
        check_word("resp_rdata", got, shadow_word(a + 32'd8));
        check_count("mem commands", cmd_addr_q.size(), 0);
    endtask

    task automatic strobed_write();
        addr_t a;
        word_t wd;
        word_t exp;
        word_t got;
        a  = 32'h0000_3458;
        wd = 64'h1122_3344_5566_7788;
        exp = apply_strobe(shadow_word(a), wd, 8'h5a);
        access(a, 1'b1, wd, 8'h5a, got);   // write miss, merged into refill
        check_word("resp_rdata", got, exp);
        update_shadow(a, wd, 8'h5a);
        access(a, 1'b0, '0, '0, got);
        check_word("resp_rdata", got, shadow_word(a));
        // second store lands on a hit
        exp = apply_strobe(shadow_word(a), ~wd, 8'hc3);
        access(a, 1'b1, ~wd, 8'hc3, got);
        check_word("resp_rdata", got, exp);
        update_shadow(a, ~wd, 8'hc3);
        access(a, 1'b0, '0, '0, got);
        check_word("resp_rdata", got, shadow_word(a));
    endtask

    task automatic dirty_eviction();
        addr_t a0;
        addr_t a1;
        addr_t a2;
        addr_t rb [6];
        word_t exp;
        word_t got;
        a0 = 32'h0000_0a50;   // tag 1, set 0x25
        a1 = 32'h0000_1258;   // tag 2, word 1
        a2 = 32'h0000_1a50;   // tag 3
        exp = apply_strobe(shadow_word(a0), 64'hdead_beef_0123_4567, 8'hff);
        access(a0, 1'b1, 64'hdead_beef_0123_4567, 8'hff, got);
        check_word("resp_rdata", got, exp);
        update_shadow(a0, 64'hdead_beef_0123_4567, 8'hff);
        exp = apply_strobe(shadow_word(a1), 64'h0f1e_2d3c_4b5a_6978, 8'h0f);
        access(a1, 1'b1, 64'h0f1e_2d3c_4b5a_6978, 8'h0f, got);
        check_word("resp_rdata", got, exp);
        update_shadow(a1, 64'h0f1e_2d3c_4b5a_6978, 8'h0f);
        clear_log();
        access(a2, 1'b0, '0, '0, got);   // evicts the oldest line, a0
        check_word("resp_rdata", got, shadow_word(a2));
        check_count("mem commands", cmd_addr_q.size(), 4);
        expect_cmd(0, 1'b1, a0);
        expect_cmd(1, 1'b1, a0 + 32'd8);
        expect_cmd(2, 1'b0, a2);
        expect_cmd(3, 1'b0, a2 + 32'd8);
        check_word("mem_wdata", cmd_data_q[0], shadow_word(a0));
        check_word("mem_wdata", cmd_data_q[1], shadow_word(a0 + 32'd8));
        check_word("mem_words", mem_words[a0[`CACHE_ADDR_W-1:3]], shadow_word(a0));
        rb = '{a0, a0 + 32'd8, a1, a1 - 32'd8, a2, a2 + 32'd8};
        foreach (rb[i]) begin
            access(rb[i], 1'b0, '0, '0, got);
            check_word("resp_rdata", got, shadow_word(rb[i]));
        end
    endtask

    task automatic back_pressure();
        addr_t a;
        word_t wd;
        word_t exp [3];
        word_t got;
        a  = 32'h0000_5560;
        wd = 64'h0123_4567_89ab_cdef;
        exp[0] = shadow_word(a);
        exp[1] = apply_strobe(shadow_word(a + 32'd8), wd, 8'h3c);
        update_shadow(a + 32'd8, wd, 8'h3c);
        exp[2] = shadow_word(a + 32'd8);
        resp_ready = 1'b0;
        send_req(a, 1'b0, '0, '0);
        send_req(a + 32'd8, 1'b1, wd, 8'h3c);
        send_req(a + 32'd8, 1'b0, '0, '0);
        @(negedge clk);
        check_flag("req_ready", req_ready, 1'b0);   // queue full behind stalled controller
        while (!resp_valid) begin
            @(negedge clk);
        end
        repeat (3) begin
            @(negedge clk);
            check_flag("resp_valid", resp_valid, 1'b1);
            check_word("resp_rdata", resp_rdata, exp[0]);
            check_flag("req_ready", req_ready, 1'b0);
        end
        step();
        resp_ready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            take_resp(got);
            check_word("resp_rdata", got, exp[i]);
        end
    endtask

    initial begin
        seed       = 32'hfe3f_56bc;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_write  = 1'b0;
        req_wdata  = '0;
        req_strb   = '0;
        resp_ready = 1'b1;
        mem_ready  = 1'b1;   // memory never stalls commands
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        reset_state();
        miss_then_hit();
        strobed_write();
        dirty_eviction();
        back_pressure();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
cache_pkg.sv
mem_pkg.sv
line_xfer_if.sv
req_queue.sv
dcache_ctrl.sv
line_mover.sv
dcache_top.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then search the log for the failure line
verilator --binary --timing --top-module tb_dcache -f all.f -o sim_dcache > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || grep -q "Test completed successfully" sim.log
